//--- design/exu_pkg.sv
// Widths are fixed for RV32 with a halfword PC and the bypass order is R, LSU M, X, nonblocking load
`default_nettype none

package exu_pkg;

   localparam int XLEN     = 32;  // Data width
   localparam int PC_W     = 31;  // PC bits 31 down to 1
   localparam int GHR_SIZE = 8;   // Global history length
   localparam int BYP_SRCS = 4;   // Bypass sources

   typedef enum logic [3:0] {
      ALU_ADD = 4'd0,
      ALU_SUB = 4'd1,
      ALU_AND = 4'd2,
      ALU_OR  = 4'd3,
      ALU_XOR = 4'd4,
      ALU_SLT = 4'd5,
      ALU_LUI = 4'd6,
      ALU_JAL = 4'd7,
      ALU_BEQ = 4'd8,
      ALU_BNE = 4'd9,
      ALU_BLT = 4'd10,
      ALU_BGE = 4'd11
   } alu_op_e;

   typedef struct packed {
      logic        valid;
      alu_op_e     op;
      logic [11:0] br_imm;  // Branch offset in halfwords
   } alu_pkt_t;

   typedef struct packed {
      logic [BYP_SRCS-1:0] rs1_byp;    // At most one bit set
      logic [BYP_SRCS-1:0] rs2_byp;    // At most one bit set
      logic                rs1_en;     // GPR RS1 qualifier
      logic                rs2_en;     // GPR RS2 qualifier
      logic                select_pc;  // PC onto RS1 for jal
      logic                qual_lsu;   // LSU instruction in D
   } opsel_t;

   typedef struct packed {
      logic [XLEN-1:0] result_r;  // Bypass bit 0
      logic [XLEN-1:0] lsu_m;     // Bypass bit 1
      logic [XLEN-1:0] result_x;  // Bypass bit 2
      logic [XLEN-1:0] nb_load;   // Bypass bit 3
   } byp_data_t;

   typedef struct packed {
      logic       valid;
      logic       ataken;  // Predicted or actual taken
      logic       misp;
      logic       pc4;     // 4-byte instruction
      logic [1:0] hist;
   } predict_pkt_t;

endpackage

`default_nettype wire

//--- design/exu_operand_mux.sv
// Purely combinational and decode must keep each bypass vector one-hot or zero
`default_nettype none

module exu_operand_mux import exu_pkg::*; (
   input  opsel_t          i_opsel,
   input  byp_data_t       i_byp,
   input  logic [PC_W-1:0] i_pc_d,
   input  logic [XLEN-1:0] i_gpr_rs1_d,
   input  logic [XLEN-1:0] i_gpr_rs2_d,
   input  logic [XLEN-1:0] i_immed_d,
   output logic [XLEN-1:0] o_rs1_d,
   output logic [XLEN-1:0] o_rs2_d,
   output logic [XLEN-1:0] o_lsu_rs1_d,
   output logic [XLEN-1:0] o_lsu_rs2_d
);

   logic            rs1_byp_en;
   logic            rs2_byp_en;
   logic [XLEN-1:0] rs1_byp_data;
   logic [XLEN-1:0] rs2_byp_data;
   logic [XLEN-1:0] rs1_reg;  // Bypass or GPR, no PC
   logic [XLEN-1:0] rs2_reg;  // Bypass or GPR, no immediate

   // AND-OR pick of the bypass word
   function automatic logic [XLEN-1:0] byp_pick(input logic [BYP_SRCS-1:0] sel,
                                                input byp_data_t byp);
      byp_pick = ({XLEN{sel[0]}} & byp.result_r) |
                 ({XLEN{sel[1]}} & byp.lsu_m)    |
                 ({XLEN{sel[2]}} & byp.result_x) |
                 ({XLEN{sel[3]}} & byp.nb_load);
   endfunction

   assign rs1_byp_en   = |i_opsel.rs1_byp;
   assign rs2_byp_en   = |i_opsel.rs2_byp;
   assign rs1_byp_data = byp_pick(i_opsel.rs1_byp, i_byp);
   assign rs2_byp_data = byp_pick(i_opsel.rs2_byp, i_byp);

   assign rs1_reg = rs1_byp_en     ? rs1_byp_data :
                    i_opsel.rs1_en ? i_gpr_rs1_d  : '0;
   assign rs2_reg = rs2_byp_en     ? rs2_byp_data :
                    i_opsel.rs2_en ? i_gpr_rs2_d  : '0;

   assign o_rs1_d = rs1_byp_en        ? rs1_byp_data  :
                    i_opsel.select_pc ? {i_pc_d, 1'b0} : rs1_reg;  // PC for jal
   assign o_rs2_d = (rs2_byp_en | i_opsel.rs2_en) ? rs2_reg : i_immed_d;

   assign o_lsu_rs1_d = i_opsel.qual_lsu ? rs1_reg : '0;  // Quiet unless LSU op
   assign o_lsu_rs2_d = i_opsel.qual_lsu ? rs2_reg : '0;

   always_comb begin
      a_byp_onehot: assert final ($onehot0(i_opsel.rs1_byp) && $onehot0(i_opsel.rs2_byp))
         else $error("bypass select has more than one source");
   end

endmodule

`default_nettype wire

//--- design/exu_alu_branch.sv
// Loads X on i_x_en and only a lower flush clears the X valid bits so decode drops wrong-path work
`default_nettype none

module exu_alu_branch import exu_pkg::*; (
   input  logic            clk,
   input  logic            i_rst_n,
   input  logic            i_x_en,
   input  alu_pkt_t        i_alu_pkt,
   input  predict_pkt_t    i_predict_d,
   input  logic [XLEN-1:0] i_rs1_d,
   input  logic [XLEN-1:0] i_rs2_d,
   input  logic [PC_W-1:0] i_pc_d,
   input  logic            i_flush_lower_r,
   output logic [XLEN-1:0] o_result_x,
   output logic [PC_W-1:0] o_pc_x,
   output predict_pkt_t    o_predict_x,
   output logic            o_flush_upper_x,
   output logic [PC_W-1:0] o_flush_path_x
);

   alu_pkt_t        alu_x;
   predict_pkt_t    pred_x;
   logic [XLEN-1:0] rs1_x;
   logic [XLEN-1:0] rs2_x;
   logic [PC_W-1:0] pc_x;
   logic            eq_x;
   logic            lt_x;       // Signed compare
   logic            is_br_x;
   logic            branch_x;   // Valid predicted branch in X
   logic            taken_x;    // Actual outcome
   logic [PC_W-1:0] br_off_x;
   logic [PC_W-1:0] seq_off_x;

   always_ff @(posedge clk) begin
      if (i_x_en) begin
         rs1_x <= i_rs1_d;
         rs2_x <= i_rs2_d;
         pc_x  <= i_pc_d;
      end
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         alu_x  <= '0;
         pred_x <= '0;
      end else if (i_x_en) begin
         alu_x        <= i_alu_pkt;
         alu_x.valid  <= i_alu_pkt.valid & ~i_flush_lower_r;
         pred_x       <= i_predict_d;
         pred_x.valid <= i_predict_d.valid & ~i_flush_lower_r;
      end else if (i_flush_lower_r) begin
         alu_x.valid  <= 1'b0;  // Kill held X content
         pred_x.valid <= 1'b0;
      end
   end

   assign eq_x     = (rs1_x == rs2_x);
   assign lt_x     = ($signed(rs1_x) < $signed(rs2_x));
   assign is_br_x  = alu_x.op inside {ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE};
   assign branch_x = alu_x.valid & pred_x.valid & is_br_x;

   always_comb begin
      case (alu_x.op)
         ALU_ADD: o_result_x = rs1_x + rs2_x;
         ALU_SUB: o_result_x = rs1_x - rs2_x;
         ALU_AND: o_result_x = rs1_x & rs2_x;
         ALU_OR:  o_result_x = rs1_x | rs2_x;
         ALU_XOR: o_result_x = rs1_x ^ rs2_x;
         ALU_SLT: o_result_x = {{(XLEN-1){1'b0}}, lt_x};
         ALU_LUI: o_result_x = rs2_x;  // Upper immediate comes on RS2
         ALU_JAL: o_result_x = {pc_x, 1'b0} + (pred_x.pc4 ? XLEN'(4) : XLEN'(2));
         default: o_result_x = '0;     // Branches write nothing
      endcase
   end

   always_comb begin
      case (alu_x.op)
         ALU_BEQ: taken_x = eq_x;
         ALU_BNE: taken_x = ~eq_x;
         ALU_BLT: taken_x = lt_x;
         ALU_BGE: taken_x = ~lt_x;
         default: taken_x = 1'b0;
      endcase
   end

   always_comb begin
      o_predict_x        = pred_x;
      o_predict_x.valid  = branch_x;
      o_predict_x.ataken = branch_x & taken_x;                  // Actual replaces predicted
      o_predict_x.misp   = branch_x & (taken_x ^ pred_x.ataken);
   end

   assign br_off_x  = {{(PC_W-12){alu_x.br_imm[11]}}, alu_x.br_imm};
   assign seq_off_x = pred_x.pc4 ? PC_W'(2) : PC_W'(1);  // Halfword units

   assign o_flush_upper_x = o_predict_x.misp;
   assign o_flush_path_x  = pc_x + (taken_x ? br_off_x : seq_off_x);
   assign o_pc_x          = pc_x;

   // Trap unit redirect lasts one cycle
   a_lower_pulse: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_flush_lower_r |=> !i_flush_lower_r)
      else $error("lower flush held for more than one cycle");

endmodule

`default_nettype wire

//--- design/exu_ghr.sv
// Both histories move only with i_x_en and a lower flush copies the X history back into D
`default_nettype none

module exu_ghr import exu_pkg::*; (
   input  logic                clk,
   input  logic                i_rst_n,
   input  logic                i_x_en,
   input  predict_pkt_t        i_predict_d,
   input  logic                i_alu_valid_d,
   input  predict_pkt_t        i_predict_x,
   input  logic                i_flush_upper_x,
   input  logic                i_flush_lower_r,
   output logic [GHR_SIZE-1:0] o_mp_ghr
);

   logic [GHR_SIZE-1:0] ghr_d;    // Speculative history
   logic [GHR_SIZE-1:0] ghr_x;    // Resolved history
   logic                shift_d;
   logic                shift_x;

   assign shift_d = i_x_en & i_predict_d.valid & i_alu_valid_d;  // Branch leaves D
   assign shift_x = i_x_en & i_predict_x.valid & ~i_flush_lower_r;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         ghr_d <= '0;
      end else if (i_flush_lower_r) begin
         ghr_d <= ghr_x;  // Restore
      end else if (shift_d) begin
         ghr_d <= {ghr_d[GHR_SIZE-2:0], i_predict_d.ataken};
      end
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         ghr_x <= '0;
      end else if (shift_x) begin
         ghr_x <= {ghr_x[GHR_SIZE-2:0], i_predict_x.ataken};
      end
   end

   assign o_mp_ghr = (i_flush_upper_x & ~i_flush_lower_r) ? ghr_d : ghr_x;

endmodule

`default_nettype wire

//--- design/exu_branch_r.sv
// R packet moves on i_r_en only and the lower flush always wins the final redirect
`default_nettype none

module exu_branch_r import exu_pkg::*; (
   input  logic            clk,
   input  logic            i_rst_n,
   input  logic            i_r_en,
   input  predict_pkt_t    i_predict_x,
   input  logic            i_flush_upper_x,
   input  logic [PC_W-1:0] i_flush_path_x,
   input  logic            i_flush_lower_r,
   input  logic [PC_W-1:0] i_flush_path_r,
   output predict_pkt_t    o_predict_r,
   output logic            o_flush_final,
   output logic [PC_W-1:0] o_flush_path_final
);

   predict_pkt_t pkt_r;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pkt_r <= '0;
      end else if (i_r_en) begin
         pkt_r      <= i_predict_x;
         pkt_r.hist <= i_predict_x.valid ? i_predict_x.hist : 2'b00;  // Predictor update only
      end
   end

   assign o_predict_r = pkt_r;

   assign o_flush_final      = i_flush_lower_r | i_flush_upper_x;
   assign o_flush_path_final = i_flush_lower_r ? i_flush_path_r : i_flush_path_x;  // Oldest first

endmodule

`default_nettype wire

//--- design/exu_top.sv
// Integer execute stage without mul/div or CSR, where i_data_en is {X, R} as levels and flushes pulse
`default_nettype none

module exu_top import exu_pkg::*; (
   input  logic                clk,
   input  logic                i_rst_n,
   input  logic [1:0]          i_data_en,
   input  alu_pkt_t            i_alu_pkt,
   input  opsel_t              i_opsel,
   input  predict_pkt_t        i_predict_d,
   input  logic [PC_W-1:0]     i_pc_d,
   input  logic [XLEN-1:0]     i_gpr_rs1_d,
   input  logic [XLEN-1:0]     i_gpr_rs2_d,
   input  logic [XLEN-1:0]     i_immed_d,
   input  logic [XLEN-1:0]     i_result_r,
   input  logic [XLEN-1:0]     i_lsu_result_m,
   input  logic [XLEN-1:0]     i_nb_load_data,
   input  logic                i_flush_lower_r,
   input  logic [PC_W-1:0]     i_flush_path_r,
   output logic [XLEN-1:0]     o_lsu_rs1_d,
   output logic [XLEN-1:0]     o_lsu_rs2_d,
   output logic [XLEN-1:0]     o_result_x,
   output logic [PC_W-1:0]     o_pc_x,
   output logic                o_flush_final,
   output logic [PC_W-1:0]     o_flush_path_final,
   output logic [GHR_SIZE-1:0] o_mp_ghr,
   output predict_pkt_t        o_predict_r
);

   byp_data_t       byp;
   logic [XLEN-1:0] rs1_d;
   logic [XLEN-1:0] rs2_d;
   predict_pkt_t    predict_x;
   logic            flush_upper_x;
   logic [PC_W-1:0] flush_path_x;

   always_comb begin
      byp.result_r = i_result_r;
      byp.lsu_m    = i_lsu_result_m;
      byp.result_x = o_result_x;  // X result fed back
      byp.nb_load  = i_nb_load_data;
   end

   exu_operand_mux u_operand_mux (
      .i_opsel     (i_opsel),
      .i_byp       (byp),
      .i_pc_d      (i_pc_d),
      .i_gpr_rs1_d (i_gpr_rs1_d),
      .i_gpr_rs2_d (i_gpr_rs2_d),
      .i_immed_d   (i_immed_d),
      .o_rs1_d     (rs1_d),
      .o_rs2_d     (rs2_d),
      .o_lsu_rs1_d (o_lsu_rs1_d),
      .o_lsu_rs2_d (o_lsu_rs2_d)
   );

   exu_alu_branch u_alu_branch (
      .clk             (clk),
      .i_rst_n         (i_rst_n),
      .i_x_en          (i_data_en[1]),
      .i_alu_pkt       (i_alu_pkt),
      .i_predict_d     (i_predict_d),
      .i_rs1_d         (rs1_d),
      .i_rs2_d         (rs2_d),
      .i_pc_d          (i_pc_d),
      .i_flush_lower_r (i_flush_lower_r),
      .o_result_x      (o_result_x),
      .o_pc_x          (o_pc_x),
      .o_predict_x     (predict_x),
      .o_flush_upper_x (flush_upper_x),
      .o_flush_path_x  (flush_path_x)
   );

   exu_ghr u_ghr (
      .clk             (clk),
      .i_rst_n         (i_rst_n),
      .i_x_en          (i_data_en[1]),
      .i_predict_d     (i_predict_d),
      .i_alu_valid_d   (i_alu_pkt.valid),
      .i_predict_x     (predict_x),
      .i_flush_upper_x (flush_upper_x),
      .i_flush_lower_r (i_flush_lower_r),
      .o_mp_ghr        (o_mp_ghr)
   );

   exu_branch_r u_branch_r (
      .clk                (clk),
      .i_rst_n            (i_rst_n),
      .i_r_en             (i_data_en[0]),
      .i_predict_x        (predict_x),
      .i_flush_upper_x    (flush_upper_x),
      .i_flush_path_x     (flush_path_x),
      .i_flush_lower_r    (i_flush_lower_r),
      .i_flush_path_r     (i_flush_path_r),
      .o_predict_r        (o_predict_r),
      .o_flush_final      (o_flush_final),
      .o_flush_path_final (o_flush_path_final)
   );

endmodule

`default_nettype wire

//--- test/tb_exu_model.svh
// Reference model of the execute stage, included inside the testbench module after its signals
`ifndef TB_EXU_MODEL_SVH
`define TB_EXU_MODEL_SVH

alu_pkt_t            m_alu;     // X stage control
predict_pkt_t        m_pred;
logic [XLEN-1:0]     m_rs1;
logic [XLEN-1:0]     m_rs2;
logic [PC_W-1:0]     m_pc;
predict_pkt_t        m_pkt_r;   // R stage packet
logic [GHR_SIZE-1:0] m_ghr_d;
logic [GHR_SIZE-1:0] m_ghr_x;
logic                m_loaded;  // X data written at least once

function automatic logic [XLEN-1:0] pick_byp(input logic [BYP_SRCS-1:0] sel, input byp_data_t b);
   case (sel)
      4'b0001: return b.result_r;
      4'b0010: return b.lsu_m;
      4'b0100: return b.result_x;
      4'b1000: return b.nb_load;
      default: return '0;
   endcase
endfunction

function automatic logic [XLEN-1:0] model_rs1(input opsel_t s, input byp_data_t b,
                                              input logic [PC_W-1:0] pc,
                                              input logic [XLEN-1:0] gpr);
   if (s.rs1_byp != 0) return pick_byp(s.rs1_byp, b);
   if (s.select_pc) return {pc, 1'b0};
   return s.rs1_en ? gpr : '0;
endfunction

function automatic logic [XLEN-1:0] model_rs2(input opsel_t s, input byp_data_t b,
                                              input logic [XLEN-1:0] gpr,
                                              input logic [XLEN-1:0] imm);
   if (s.rs2_byp != 0) return pick_byp(s.rs2_byp, b);
   return s.rs2_en ? gpr : imm;
endfunction

// LSU operand ignores PC and immediate
function automatic logic [XLEN-1:0] model_lsu(input logic qual, input logic [BYP_SRCS-1:0] sel,
                                              input logic en, input byp_data_t b,
                                              input logic [XLEN-1:0] gpr);
   if (!qual) return '0;
   if (sel != 0) return pick_byp(sel, b);
   return en ? gpr : '0;
endfunction

function automatic logic model_taken(input alu_op_e op, input logic [XLEN-1:0] a,
                                     input logic [XLEN-1:0] b);
   case (op)
      ALU_BEQ: return a == b;
      ALU_BNE: return a != b;
      ALU_BLT: return $signed(a) < $signed(b);
      ALU_BGE: return $signed(a) >= $signed(b);
      default: return 1'b0;
   endcase
endfunction

function automatic logic [XLEN-1:0] model_result();
   case (m_alu.op)
      ALU_ADD: return m_rs1 + m_rs2;
      ALU_SUB: return m_rs1 - m_rs2;
      ALU_AND: return m_rs1 & m_rs2;
      ALU_OR:  return m_rs1 | m_rs2;
      ALU_XOR: return m_rs1 ^ m_rs2;
      ALU_SLT: return ($signed(m_rs1) < $signed(m_rs2)) ? 32'd1 : 32'd0;
      ALU_LUI: return m_rs2;
      ALU_JAL: return {m_pc, 1'b0} + (m_pred.pc4 ? 32'd4 : 32'd2);
      default: return '0;
   endcase
endfunction

function automatic predict_pkt_t model_x_pkt();
   predict_pkt_t p;
   logic         br;
   logic         tk;
   br = m_alu.valid & m_pred.valid & (m_alu.op inside {ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE});
   tk = model_taken(m_alu.op, m_rs1, m_rs2);
   p = m_pred;
   p.valid  = br;
   p.ataken = br & tk;
   p.misp   = br & (tk ^ m_pred.ataken);
   return p;
endfunction

function automatic logic [PC_W-1:0] model_target();
   if (model_taken(m_alu.op, m_rs1, m_rs2))
      return m_pc + {{(PC_W-12){m_alu.br_imm[11]}}, m_alu.br_imm};
   return m_pc + (m_pred.pc4 ? 31'd2 : 31'd1);
endfunction

task automatic model_reset();
   m_alu    = '0;
   m_pred   = '0;
   m_pkt_r  = '0;
   m_ghr_d  = '0;
   m_ghr_x  = '0;
   m_loaded = 1'b0;
endtask

// One rising edge, all updates from the old state
task automatic model_step(input logic en_x, input logic en_r, input alu_pkt_t alu,
                          input predict_pkt_t pred, input logic [XLEN-1:0] rs1,
                          input logic [XLEN-1:0] rs2, input logic [PC_W-1:0] pc,
                          input logic lower);
   predict_pkt_t xp;
   xp = model_x_pkt();
   if (en_r) begin
      m_pkt_r = xp;
      if (!xp.valid) m_pkt_r.hist = 2'b00;
   end
   if (lower) m_ghr_d = m_ghr_x;
   else if (en_x && pred.valid && alu.valid) m_ghr_d = {m_ghr_d[GHR_SIZE-2:0], pred.ataken};
   if (en_x && xp.valid && !lower) m_ghr_x = {m_ghr_x[GHR_SIZE-2:0], xp.ataken};
   if (en_x) begin
      m_alu        = alu;
      m_alu.valid  = alu.valid & ~lower;
      m_pred       = pred;
      m_pred.valid = pred.valid & ~lower;
      m_rs1        = rs1;
      m_rs2        = rs2;
      m_pc         = pc;
      m_loaded     = 1'b1;
   end else if (lower) begin
      m_alu.valid  = 1'b0;
      m_pred.valid = 1'b0;
   end
endtask

`endif

//--- test/tb_exu.sv
// Random execute-stage run against the included model, fixed seed, one D instruction per cycle
`default_nettype none

module tb_exu import exu_pkg::*; ();

   logic                clk = 1'b0;
   logic                i_rst_n;
   logic [1:0]          i_data_en;
   alu_pkt_t            i_alu_pkt;
   opsel_t              i_opsel;
   predict_pkt_t        i_predict_d;
   logic [PC_W-1:0]     i_pc_d;
   logic [XLEN-1:0]     i_gpr_rs1_d;
   logic [XLEN-1:0]     i_gpr_rs2_d;
   logic [XLEN-1:0]     i_immed_d;
   logic [XLEN-1:0]     i_result_r;
   logic [XLEN-1:0]     i_lsu_result_m;
   logic [XLEN-1:0]     i_nb_load_data;
   logic                i_flush_lower_r;
   logic [PC_W-1:0]     i_flush_path_r;
   logic [XLEN-1:0]     o_lsu_rs1_d;
   logic [XLEN-1:0]     o_lsu_rs2_d;
   logic [XLEN-1:0]     o_result_x;
   logic [PC_W-1:0]     o_pc_x;
   logic                o_flush_final;
   logic [PC_W-1:0]     o_flush_path_final;
   logic [GHR_SIZE-1:0] o_mp_ghr;
   predict_pkt_t        o_predict_r;
   logic [31:0]         lfsr_state = 32'h42c1_8bdb;
   int                  n_misp;
   int                  n_lower;

   `include "tb_exu_model.svh"

   exu_top u_exu_top (.*);

   always #10 clk = ~clk;

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         v          = {v[30:0], fb};
      end
      return v;
   endfunction

   function automatic logic [BYP_SRCS-1:0] byp_choice(input logic [2:0] k);
      return (k < 3'd4) ? (4'b0001 << k) : 4'b0000;  // Half the time no bypass
   endfunction

   function automatic alu_op_e op_choice(input logic [2:0] k);
      case (k)
         3'd0: return ALU_ADD;
         3'd1: return ALU_XOR;
         3'd2: return ALU_SLT;
         3'd3: return ALU_JAL;
         3'd4: return ALU_BEQ;
         3'd5: return ALU_BNE;
         3'd6: return ALU_BLT;
         default: return ALU_BGE;
      endcase
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
      $display(">>> FAIL");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
      if (got !== exp) report_mismatch(name, got, exp);
   endtask

   task automatic check_pc(input string name, input logic [PC_W-1:0] got,
                           input logic [PC_W-1:0] exp);
      if (got !== exp) report_mismatch(name, {1'b0, got}, {1'b0, exp});
   endtask

   task automatic check_ghr(input string name, input logic [GHR_SIZE-1:0] got,
                            input logic [GHR_SIZE-1:0] exp);
      if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
   endtask

   task automatic check_pkt(input string name, input predict_pkt_t got,
                            input predict_pkt_t exp);
      if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
   endtask

   task automatic drive_idle();
      i_data_en       = 2'b11;
      i_alu_pkt       = '0;
      i_opsel         = '0;
      i_predict_d     = '0;
      i_flush_lower_r = 1'b0;
   endtask

   task automatic drive_random();
      logic en_x;
      en_x                  = (rand_bits(3) != 0);  // 7 in 8
      i_data_en             = {en_x, en_x};
      i_alu_pkt.valid       = (rand_bits(3) != 0);
      i_alu_pkt.op          = op_choice(rand_bits(3));
      i_alu_pkt.br_imm      = rand_bits(12);
      i_opsel.rs1_byp       = byp_choice(rand_bits(3));
      i_opsel.rs2_byp       = byp_choice(rand_bits(3));
      i_opsel.rs1_en        = rand_bits(1);
      i_opsel.rs2_en        = rand_bits(1);
      i_opsel.select_pc     = (rand_bits(2) == 0);
      i_opsel.qual_lsu      = rand_bits(1);
      i_predict_d.valid     = (rand_bits(2) != 0);
      i_predict_d.ataken    = rand_bits(1);
      i_predict_d.misp      = rand_bits(1);  // Must be replaced in X
      i_predict_d.pc4       = rand_bits(1);
      i_predict_d.hist      = rand_bits(2);
      i_pc_d                = rand_bits(31);
      i_gpr_rs1_d           = rand_bits(32);
      i_gpr_rs2_d           = rand_bits(1) ? i_gpr_rs1_d : rand_bits(32);  // Equal operands
      i_immed_d             = rand_bits(32);
      i_result_r            = rand_bits(32);
      i_lsu_result_m        = rand_bits(32);
      i_nb_load_data        = rand_bits(32);
      i_flush_path_r        = rand_bits(31);
      i_flush_lower_r       = !i_flush_lower_r && (rand_bits(4) == 0);  // Single-cycle pulse
   endtask

   // Checks the settled outputs, then advances the model past the next edge
   task automatic check_and_step();
      byp_data_t       b;
      predict_pkt_t    xp;
      logic [XLEN-1:0] rs1;
      logic [XLEN-1:0] rs2;
      logic            fl;
      b.result_r = i_result_r;
      b.lsu_m    = i_lsu_result_m;
      b.result_x = model_result();
      b.nb_load  = i_nb_load_data;
      rs1 = model_rs1(i_opsel, b, i_pc_d, i_gpr_rs1_d);
      rs2 = model_rs2(i_opsel, b, i_gpr_rs2_d, i_immed_d);
      xp  = model_x_pkt();
      fl  = xp.misp | i_flush_lower_r;
      check_word("o_lsu_rs1_d", o_lsu_rs1_d,
                 model_lsu(i_opsel.qual_lsu, i_opsel.rs1_byp, i_opsel.rs1_en, b, i_gpr_rs1_d));
      check_word("o_lsu_rs2_d", o_lsu_rs2_d,
                 model_lsu(i_opsel.qual_lsu, i_opsel.rs2_byp, i_opsel.rs2_en, b, i_gpr_rs2_d));
      if (m_loaded) begin
         check_word("o_result_x", o_result_x, b.result_x);
         check_pc("o_pc_x", o_pc_x, m_pc);
      end
      check_word("o_flush_final", 32'(o_flush_final), 32'(fl));
      if (fl) check_pc("o_flush_path_final", o_flush_path_final,
                       i_flush_lower_r ? i_flush_path_r : model_target());
      check_ghr("o_mp_ghr", o_mp_ghr, (xp.misp && !i_flush_lower_r) ? m_ghr_d : m_ghr_x);
      check_pkt("o_predict_r", o_predict_r, m_pkt_r);
      n_misp  += xp.misp;
      n_lower += i_flush_lower_r;
      model_step(i_data_en[1], i_data_en[0], i_alu_pkt, i_predict_d, rs1, rs2, i_pc_d,
                 i_flush_lower_r);
   endtask

   task automatic run_cycle(input logic random);
      @(posedge clk);
      #2;
      if (random) drive_random();
      else drive_idle();
      #10;
      check_and_step();
   endtask

   initial begin
      int wait_cnt;
      i_rst_n        = 1'b0;
      i_pc_d         = '0;
      i_gpr_rs1_d    = '0;
      i_gpr_rs2_d    = '0;
      i_immed_d      = '0;
      i_result_r     = '0;
      i_lsu_result_m = '0;
      i_nb_load_data = '0;
      i_flush_path_r = '0;
      n_misp         = 0;
      n_lower        = 0;
      drive_idle();
      i_data_en = 2'b00;
      model_reset();
      repeat (2) @(posedge clk);
      #2;
      i_rst_n = 1'b1;
      #10;
      check_word("o_flush_final", 32'(o_flush_final), 32'd0);
      check_pkt("o_predict_r", o_predict_r, '0);
      check_ghr("o_mp_ghr", o_mp_ghr, '0);
      for (int i = 0; i < 3000; i++) run_cycle(1'b1);
      // Drain until no redirect is pending
      wait_cnt = 0;
      do begin
         run_cycle(1'b0);
         wait_cnt++;
      end while (o_flush_final && wait_cnt < 200);
      if (o_flush_final) begin
         $display("Timeout: the flush output stayed high after the pipeline was drained");
         $display(">>> FAIL");
         $fatal(1);
      end else if (n_misp == 0 || n_lower == 0) begin
         $display("The random run produced no mispredict or no lower flush");
         $display(">>> FAIL");
         $fatal(1);
      end else begin
         $display(">>> PASS");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- flist.f
+incdir+test
design/exu_pkg.sv
design/exu_operand_mux.sv
design/exu_alu_branch.sv
design/exu_ghr.sv
design/exu_branch_r.sv
design/exu_top.sv
test/tb_exu.sv

//--- Bender.yml
package:
  name: exu

sources:
  - design/exu_pkg.sv
  - design/exu_operand_mux.sv
  - design/exu_alu_branch.sv
  - design/exu_ghr.sv
  - design/exu_branch_r.sv
  - design/exu_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_exu.sv
